//--- tb.f
+incdir+src
src/user_io_pkg.sv
src/spi_cmd_decode.sv
src/hid_execute.sv
src/kbd_mouse_queue.sv
src/user_io_top.sv
tb/user_io_props.sv
tb/user_io_tb.sv

//--- run.sh
#!/bin/sh
# build the user_io testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module user_io_tb -o user_io_sim \
  || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/user_io_sim 2>&1)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "Testbench passed" \
  && echo "simulation run ok" \
  || { echo "simulation run not ok"; exit 1; }

//--- tb/user_io_tb.sv
//////////////////////////////////////////////////
// user_io testbench: spi frame driver, hid
// reference model, event compare, watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "user_io_defs.svh"
`default_nettype none

module user_io_tb;

  import user_io_pkg::*;

  localparam int HALF         = 8;                 // sck half period in clk_28 cycles
  localparam int BYTE_CYC     = 2 * HALF * 8;
  localparam int N_REG        = 6;                 // rounds of buttons / joy0 / joy1
  localparam int N_NONE       = 4;                 // unknown opcode frames
  localparam int N_MOUSE      = 3;
  localparam int KBD_SHORT    = 5;
  localparam int KBD_LONG     = `HID_QUEUE_DEPTH + `HID_INIT_CREDITS + 3;
  localparam int N_FRAMES     = 1 + 3 * N_REG + N_NONE + N_MOUSE + 2;
  localparam int FRAME_CYC    = (KBD_LONG + 1) * BYTE_CYC + 4 * HALF; // longest frame
  localparam int WATCHDOG_CYC = N_FRAMES * FRAME_CYC + 4000;          // drains + margin
  localparam int DRAIN_CYC    = 16 * (`HID_QUEUE_DEPTH + `HID_INIT_CREDITS);
  localparam logic [7:0] CORE_ID = `USER_IO_CORE_ID;

  logic       clk_28;
  logic       pll_locked;
  logic       spi_sck;
  logic       spi_ss_n;
  logic       spi_mosi;
  logic       spi_miso;
  logic       credit_return;
  logic [5:0] joy0;
  logic [5:0] joy1;
  logic [1:0] board_buttons;
  logic [1:0] board_switches;
  logic [2:0] mouse_buttons;
  logic [7:0] kbd_mouse_data;
  km_type_e   kbd_mouse_type;
  logic       kbd_mouse_strobe;
  logic       queue_overflow;

  // reference state
  logic [5:0] exp_joy0;
  logic [5:0] exp_joy1;
  logic [1:0] exp_buttons;
  logic [1:0] exp_switches;
  logic [2:0] exp_mbuttons;
  logic       exp_overflow;
  logic [9:0] exp_q [$];     // {type, data} not yet strobed
  int         ref_credits;   // credits the queue holds
  int         strobe_count;
  int         base;
  integer     seed = 32'h3503;
  string      cur_test;

  user_io_top u_user_io_top (
    .clk_28           (clk_28          ),
    .pll_locked       (pll_locked      ),
    .spi_sck          (spi_sck         ),
    .spi_ss_n         (spi_ss_n        ),
    .spi_mosi         (spi_mosi        ),
    .spi_miso         (spi_miso        ),
    .credit_return    (credit_return   ),
    .joy0             (joy0            ),
    .joy1             (joy1            ),
    .board_buttons    (board_buttons   ),
    .board_switches   (board_switches  ),
    .mouse_buttons    (mouse_buttons   ),
    .kbd_mouse_data   (kbd_mouse_data  ),
    .kbd_mouse_type   (kbd_mouse_type  ),
    .kbd_mouse_strobe (kbd_mouse_strobe),
    .queue_overflow   (queue_overflow  )
  );

  always #4 clk_28 = ~clk_28; // 8 ns period

  //////////////////////////////////////////////////
  // error reporting and checks
  //////////////////////////////////////////////////

  task automatic fail_run();
    $display("Testbench failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic stop_on_failure(input string what);
    $display("ERROR: %s", what);
    fail_run();
  endtask

  task automatic report_mismatch(input string test, input string sig,
                                 input logic [31:0] expv, input logic [31:0] actv);
    $display("CHECK FAILED test=%s %s expected=%0h actual=%0h", test, sig, expv, actv);
    fail_run();
  endtask

  task automatic check_value(input string test, input string sig,
                             input logic [31:0] expv, input logic [31:0] actv);
    assert (actv == expv) else report_mismatch(test, sig, expv, actv);
  endtask

  // for quiet cycles with no strobe expected
  task automatic check_outputs(input string test);
    check_value(test, "joy0", exp_joy0, joy0);
    check_value(test, "joy1", exp_joy1, joy1);
    check_value(test, "board_buttons", exp_buttons, board_buttons);
    check_value(test, "board_switches", exp_switches, board_switches);
    check_value(test, "mouse_buttons", exp_mbuttons, mouse_buttons);
    check_value(test, "queue_overflow", exp_overflow, queue_overflow);
    check_value(test, "kbd_mouse_strobe", 0, kbd_mouse_strobe);
    check_value(test, "spi_miso", 0, spi_miso);
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic void expect_event(input km_type_e kind, input logic [7:0] data);
    if (exp_q.size() >= `HID_QUEUE_DEPTH)
      exp_overflow = 1'b1; // undelivered events fill the queue
    else
      exp_q.push_back({kind, data});
  endfunction

  function automatic void ref_apply(input logic [7:0] op, input int idx,
                                    input logic [7:0] data);
    case (op)
      OP_BUTTONS: begin
        if (idx == 0) begin
          exp_buttons  = data[1:0];
          exp_switches = data[3:2];
        end
      end
      OP_JOY0: if (idx == 0) exp_joy0 = data[5:0];
      OP_JOY1: if (idx == 0) exp_joy1 = data[5:0];
      OP_MOUSE: begin
        if (idx == 0)
          expect_event(KM_MOUSE_X, data);
        else if (idx == 1)
          expect_event(KM_MOUSE_Y, data);
        else if (idx == 2)
          exp_mbuttons = data[2:0]; // later bytes dropped
      end
      OP_KBD: expect_event(KM_KEY, data);
      default: ; // payload of unknown opcode ignored
    endcase
  endfunction

  //////////////////////////////////////////////////
  // spi master and credit driver
  //////////////////////////////////////////////////

  task automatic send_byte(input logic [7:0] b, input logic is_payload,
                           input logic [7:0] op, input int idx,
                           output logic [7:0] miso_bits);
    for (int i = 7; i >= 0; i--) begin
      spi_mosi = b[i];               // msb first while sck is low
      repeat (HALF) @(posedge clk_28);
      #1;
      miso_bits[i] = spi_miso;       // master samples before the rise
      spi_sck = 1'b1;
      if (is_payload && (i == 0))
        ref_apply(op, idx, b);       // byte complete at this edge
      repeat (HALF) @(posedge clk_28);
      #1;
      spi_sck = 1'b0;
    end
  endtask

  task automatic send_frame(input logic [7:0] op, input int n_payload);
    logic [7:0] miso_bits;
    logic [7:0] data;
    @(posedge clk_28);
    #1;
    spi_ss_n = 1'b0;
    send_byte(op, 1'b0, op, 0, miso_bits);
    check_value(cur_test, "miso core id", CORE_ID, miso_bits);
    for (int k = 0; k < n_payload; k++) begin
      data = 8'($random(seed));
      send_byte(data, 1'b1, op, k, miso_bits);
    end
    repeat (HALF) @(posedge clk_28);
    #1;
    spi_ss_n = 1'b1;
    repeat (2 * HALF) @(posedge clk_28); // back to idle
    #1;
  endtask

  task automatic return_credit();
    @(posedge clk_28);
    #1;
    credit_return = 1'b1;
    ref_credits++;
    @(posedge clk_28);
    #1;
    credit_return = 1'b0;
  endtask

  // hand back one credit at a time until nothing is pending
  task automatic drain_and_refill();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0) && (waited < DRAIN_CYC)) begin
      if (ref_credits == 0)
        return_credit();
      else
        @(posedge clk_28);
      waited++;
    end
    assert (exp_q.size() == 0)
      else stop_on_failure("queued events were not delivered after credits came back");
    while (ref_credits < `HID_INIT_CREDITS)
      return_credit();
    repeat (4 * HALF) @(posedge clk_28);
    #1;
  endtask

  //////////////////////////////////////////////////
  // event compare
  //////////////////////////////////////////////////

  always @(negedge clk_28) begin : compare_events
    logic [9:0] head;
    if (pll_locked && kbd_mouse_strobe) begin
      assert (exp_q.size() != 0) else stop_on_failure("strobe seen with no event expected");
      assert (ref_credits > 0) else stop_on_failure("strobe seen with no credit left");
      head = exp_q.pop_front();
      check_value(cur_test, "kbd_mouse_data", head[7:0], kbd_mouse_data);
      check_value(cur_test, "kbd_mouse_type", head[9:8], kbd_mouse_type);
      ref_credits--;
      strobe_count++;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk_28);
    stop_on_failure("watchdog expired before the tests finished");
  end

  initial begin
    clk_28        = 1'b0;
    pll_locked    = 1'b0;
    spi_sck       = 1'b0;  // mode 0 idle level
    spi_ss_n      = 1'b1;
    spi_mosi      = 1'b0;
    credit_return = 1'b0;
    exp_joy0      = '0;
    exp_joy1      = '0;
    exp_buttons   = '0;
    exp_switches  = '0;
    exp_mbuttons  = '0;
    exp_overflow  = 1'b0;
    ref_credits   = `HID_INIT_CREDITS;
    strobe_count  = 0;
    cur_test      = "reset";

    repeat (10) @(posedge clk_28);
    #1;
    check_outputs(cur_test);
    pll_locked = 1'b1;
    repeat (4) @(posedge clk_28);
    #1;
    check_outputs(cur_test);
    check_value(cur_test, "kbd_mouse_data", 0, kbd_mouse_data);
    check_value(cur_test, "kbd_mouse_type", 0, kbd_mouse_type);

    cur_test = "core id";
    send_frame(8'h00, 1);
    check_outputs(cur_test);

    cur_test = "hid registers"; // extra bytes beyond index 0 ignored
    for (int r = 0; r < N_REG; r++) begin
      send_frame(OP_BUTTONS, 1 + rand_below(3));
      check_outputs(cur_test);
      send_frame(OP_JOY0, 1 + rand_below(3));
      check_outputs(cur_test);
      send_frame(OP_JOY1, 1 + rand_below(3));
      check_outputs(cur_test);
    end

    cur_test = "unknown opcode";
    for (int r = 0; r < N_NONE; r++) begin
      send_frame((r == 0) ? 8'h00 : 8'(8'h06 + rand_below(250)), 1 + rand_below(3));
      check_outputs(cur_test);
    end

    cur_test = "mouse"; // 3 bytes, 4 bytes, then 2 bytes
    for (int r = 0; r < N_MOUSE; r++) begin
      base = strobe_count;
      send_frame(OP_MOUSE, (r == 2) ? 2 : 3 + r);
      check_value(cur_test, "mouse strobes", 2, strobe_count - base);
      drain_and_refill();
      check_outputs(cur_test);
    end

    cur_test = "credit backpressure";
    base = strobe_count;
    send_frame(OP_KBD, KBD_SHORT);
    check_value(cur_test, "strobes without returns", `HID_INIT_CREDITS, strobe_count - base);
    check_value(cur_test, "events held", KBD_SHORT - `HID_INIT_CREDITS, exp_q.size());
    drain_and_refill();
    check_value(cur_test, "key strobes", KBD_SHORT, strobe_count - base);
    check_outputs(cur_test);

    cur_test = "overflow";
    base = strobe_count;
    send_frame(OP_KBD, KBD_LONG);
    check_value(cur_test, "strobes without returns", `HID_INIT_CREDITS, strobe_count - base);
    check_value(cur_test, "queue_overflow set", 1, queue_overflow);
    check_outputs(cur_test);
    drain_and_refill();
    check_value(cur_test, "key strobes", `HID_QUEUE_DEPTH + `HID_INIT_CREDITS,
                strobe_count - base);
    check_outputs(cur_test);

    if ((exp_q.size() == 0) && (ref_credits == `HID_INIT_CREDITS)) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_on_failure("events or credits left over at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- tb/user_io_props.sv
//////////////////////////////////////////////////
// credit handshake assertions for the event
// queue, bound into kbd_mouse_queue
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "user_io_defs.svh"
`default_nettype none

module user_io_props (
  input wire                                       clk_28,
  input wire                                       pll_locked,
  input wire                                       kbd_mouse_strobe,
  input wire                                       credit_return,
  input wire [$clog2(`HID_INIT_CREDITS + 1)-1:0]   credit_cnt
);

  // strobe spends a credit held the cycle before
  strobe_needs_credit: assert property (
    @(posedge clk_28) disable iff (!pll_locked)
    kbd_mouse_strobe |-> ($past(credit_cnt) != 0)
  ) else $error("strobe issued while the credit count was zero");

  credit_ceiling: assert property (
    @(posedge clk_28) disable iff (!pll_locked)
    credit_cnt <= `HID_INIT_CREDITS
  ) else $error("credit count above the initial grant");

  // last credit gone and none returned, no back to back strobe
  strobe_gap: assert property (
    @(posedge clk_28) disable iff (!pll_locked)
    (kbd_mouse_strobe && (credit_cnt == 0) && !credit_return) |=> !kbd_mouse_strobe
  ) else $error("strobe repeated without a credit in between");

endmodule

bind kbd_mouse_queue user_io_props u_props (
  .clk_28           (clk_28          ),
  .pll_locked       (pll_locked      ),
  .kbd_mouse_strobe (kbd_mouse_strobe),
  .credit_return    (credit_return   ),
  .credit_cnt       (credit_cnt      )
);

`default_nettype wire

//--- src/user_io_top.sv
//////////////////////////////////////////////////
// user_io top: spi decode, hid execute,
// event queue toward the core
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module user_io_top (
  input  wire                   clk_28,
  input  wire                   pll_locked,       // async, active low
  input  wire                   spi_sck,
  input  wire                   spi_ss_n,         // conf_data0 on the board
  input  wire                   spi_mosi,
  output logic                  spi_miso,
  input  wire                   credit_return,
  output logic [5:0]            joy0,
  output logic [5:0]            joy1,
  output logic [1:0]            board_buttons,
  output logic [1:0]            board_switches,
  output logic [2:0]            mouse_buttons,
  output logic [7:0]            kbd_mouse_data,
  output user_io_pkg::km_type_e kbd_mouse_type,
  output logic                  kbd_mouse_strobe,
  output logic                  queue_overflow
);

  import user_io_pkg::*;

  logic        byte_valid;    // decode -> execute
  logic [7:0]  rx_byte;
  uio_opcode_e opcode;
  logic [1:0]  payload_index;
  logic        push;          // execute -> queue
  logic [7:0]  push_data;
  km_type_e    push_type;

  spi_cmd_decode u_decode (
    .clk_28        (clk_28       ),
    .pll_locked    (pll_locked   ),
    .spi_sck       (spi_sck      ),
    .spi_ss_n      (spi_ss_n     ),
    .spi_mosi      (spi_mosi     ),
    .spi_miso      (spi_miso     ),
    .byte_valid    (byte_valid   ),
    .rx_byte       (rx_byte      ),
    .opcode        (opcode       ),
    .payload_index (payload_index)
  );

  hid_execute u_execute (
    .clk_28         (clk_28        ),
    .pll_locked     (pll_locked    ),
    .byte_valid     (byte_valid    ),
    .rx_byte        (rx_byte       ),
    .opcode         (opcode        ),
    .payload_index  (payload_index ),
    .joy0           (joy0          ),
    .joy1           (joy1          ),
    .board_buttons  (board_buttons ),
    .board_switches (board_switches),
    .mouse_buttons  (mouse_buttons ),
    .push           (push          ),
    .push_data      (push_data     ),
    .push_type      (push_type     )
  );

  kbd_mouse_queue u_queue (
    .clk_28           (clk_28          ),
    .pll_locked       (pll_locked      ),
    .push             (push            ),
    .push_data        (push_data       ),
    .push_type        (push_type       ),
    .credit_return    (credit_return   ),
    .kbd_mouse_strobe (kbd_mouse_strobe),
    .kbd_mouse_data   (kbd_mouse_data  ),
    .kbd_mouse_type   (kbd_mouse_type  ),
    .queue_overflow   (queue_overflow  )
  );

endmodule

`default_nettype wire

//--- src/kbd_mouse_queue.sv
//////////////////////////////////////////////////
// kbd / mouse event fifo with credit gated
// strobe toward the core
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "user_io_defs.svh"
`default_nettype none

module kbd_mouse_queue (
  input  wire                   clk_28,
  input  wire                   pll_locked,
  input  wire                   push,
  input  wire  [7:0]            push_data,
  input  user_io_pkg::km_type_e push_type,
  input  wire                   credit_return,    // one pulse per credit
  output logic                  kbd_mouse_strobe,
  output logic [7:0]            kbd_mouse_data,
  output user_io_pkg::km_type_e kbd_mouse_type,
  output logic                  queue_overflow    // sticky until reset
);

  import user_io_pkg::*;

  localparam int PTR_W = $clog2(`HID_QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam int CRD_W = $clog2(`HID_INIT_CREDITS + 1);
  localparam logic [CNT_W-1:0] DEPTH   = CNT_W'(`HID_QUEUE_DEPTH);
  localparam logic [CRD_W-1:0] MAX_CRD = CRD_W'(`HID_INIT_CREDITS);

  logic [7:0]       mem_data [0:`HID_QUEUE_DEPTH-1];
  km_type_e         mem_type [0:`HID_QUEUE_DEPTH-1];
  logic [PTR_W-1:0] wr_ptr;     // wraps at the power of two depth
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] credit_cnt;
  logic             empty;
  logic             full;
  logic             accept;
  logic             pop;
  logic [7:0]       head_data;
  km_type_e         head_type;

  assign empty  = (count == '0);
  assign full   = (count == DEPTH);
  assign accept = push && !full;
  // empty queue forwards the incoming push directly
  assign head_data = empty ? push_data : mem_data[rd_ptr];
  assign head_type = empty ? push_type : mem_type[rd_ptr];
  assign pop = (!empty || push) && (credit_cnt != '0); // head ready and a credit left

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (accept) begin
      mem_data[wr_ptr] <= push_data;
      mem_type[wr_ptr] <= push_type;
    end
  end

  //////////////////////////////////////////////////
  // pointers, credits, core outputs
  //////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      wr_ptr           <= '0;
      rd_ptr           <= '0;
      count            <= '0;
      credit_cnt       <= MAX_CRD; // core grants these at start
      kbd_mouse_strobe <= 1'b0;
      kbd_mouse_data   <= 8'd0;
      kbd_mouse_type   <= KM_MOUSE_X;
      queue_overflow   <= 1'b0;
    end else begin
      kbd_mouse_strobe <= pop;
      if (pop) begin
        kbd_mouse_data <= head_data;
        kbd_mouse_type <= head_type;
        rd_ptr         <= rd_ptr + 1'b1;
      end
      if (accept)
        wr_ptr <= wr_ptr + 1'b1;
      if (push && full)
        queue_overflow <= 1'b1; // push lost

      case ({accept, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ; // bypass or idle
      endcase

      case ({credit_return, pop})
        2'b10:   credit_cnt <= credit_cnt + 1'b1; // credit back from the core
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: ; // return and spend cancel
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/hid_execute.sv
//////////////////////////////////////////////////
// hid register file and kbd / mouse event
// generation from decoded payload bytes
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hid_execute (
  input  wire                      clk_28,
  input  wire                      pll_locked,
  input  wire                      byte_valid,
  input  wire  [7:0]               rx_byte,
  input  user_io_pkg::uio_opcode_e opcode,
  input  wire  [1:0]               payload_index,
  output logic [5:0]               joy0,
  output logic [5:0]               joy1,
  output logic [1:0]               board_buttons,
  output logic [1:0]               board_switches,
  output logic [2:0]               mouse_buttons,
  output logic                     push,        // one cycle, never stalled
  output logic [7:0]               push_data,
  output user_io_pkg::km_type_e    push_type
);

  import user_io_pkg::*;

  logic     first_byte; // index 0 of the frame
  logic     ev_byte;    // this byte becomes a queue entry
  km_type_e ev_type;

  assign first_byte = (payload_index == 2'd0);

  // which bytes turn into events and with what tag
  always_comb begin
    ev_byte = 1'b0;
    ev_type = KM_KEY;
    case (opcode)
      OP_KBD: ev_byte = 1'b1; // every keycode
      OP_MOUSE: begin
        ev_byte = (payload_index == 2'd0) || (payload_index == 2'd1);
        ev_type = first_byte ? KM_MOUSE_X : KM_MOUSE_Y;
      end
      default: ev_byte = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // hid registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      joy0           <= 6'd0;
      joy1           <= 6'd0;
      board_buttons  <= 2'd0;
      board_switches <= 2'd0;
      mouse_buttons  <= 3'd0;
      push           <= 1'b0;
    end else begin
      push <= byte_valid && ev_byte; // lines up with the register update
      if (byte_valid) begin
        case (opcode)
          OP_BUTTONS: begin
            if (first_byte) begin // extra bytes ignored
              board_buttons  <= rx_byte[1:0];
              board_switches <= rx_byte[3:2];
            end
          end
          OP_JOY0: if (first_byte) joy0 <= rx_byte[5:0];
          OP_JOY1: if (first_byte) joy1 <= rx_byte[5:0];
          OP_MOUSE: begin
            if (payload_index == 2'd2)
              mouse_buttons <= rx_byte[2:0]; // index 3 and later dropped
          end
          default: ; // keyboard only pushes, no-op ignored
        endcase
      end
    end
  end

  // event payload, qualified by push
  always_ff @(posedge clk_28) begin
    if (byte_valid) begin
      push_data <= rx_byte;
      push_type <= ev_type;
    end
  end

endmodule

`default_nettype wire

//--- src/spi_cmd_decode.sv
//////////////////////////////////////////////////
// spi slave byte receiver and frame decoder,
// core id shifted out on miso during opcode byte
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "user_io_defs.svh"
`default_nettype none

module spi_cmd_decode (
  input  wire                      clk_28,
  input  wire                      pll_locked,
  input  wire                      spi_sck,
  input  wire                      spi_ss_n,
  input  wire                      spi_mosi,
  output logic                     spi_miso,
  output logic                     byte_valid,    // one cycle per payload byte
  output logic [7:0]               rx_byte,
  output user_io_pkg::uio_opcode_e opcode,        // held for the whole frame
  output logic [1:0]               payload_index  // saturates at 3
);

  import user_io_pkg::*;

  localparam logic [7:0] CORE_ID = `USER_IO_CORE_ID;

  logic [1:0] sck_sync;   // 2-flop synchronizers
  logic [1:0] ss_sync;
  logic [1:0] mosi_sync;
  logic       sck_d;      // for edge detect
  logic       sck_rise;
  logic       sck_fall;
  logic       ss_active;
  dec_state_e state;
  logic [2:0] bit_cnt;    // bits received in current byte
  logic [6:0] rx_shift;
  logic [6:0] tx_shift;   // remaining id bits
  logic [7:0] rx_next;
  logic       byte_done;

  // anything outside 01..05 is treated as no-op
  function automatic uio_opcode_e map_opcode(input logic [7:0] b);
    case (b)
      OP_BUTTONS, OP_JOY0, OP_JOY1, OP_MOUSE, OP_KBD: map_opcode = uio_opcode_e'(b);
      default: map_opcode = OP_NONE;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // pin synchronizers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      sck_sync  <= 2'b00;
      ss_sync   <= 2'b11; // deselected
      mosi_sync <= 2'b00;
      sck_d     <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[0], spi_sck};
      ss_sync   <= {ss_sync[0], spi_ss_n};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      sck_d     <= sck_sync[1];
    end
  end

  assign sck_rise  = sck_sync[1] & ~sck_d;  // mode 0 sample edge
  assign sck_fall  = ~sck_sync[1] & sck_d;  // mode 0 shift edge
  assign ss_active = ~ss_sync[1];
  assign rx_next   = {rx_shift, mosi_sync[1]}; // msb first
  assign byte_done = sck_rise && (bit_cnt == 3'd7);

  //////////////////////////////////////////////////
  // frame fsm, byte assembly, miso
  //////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      state         <= ST_IDLE;
      bit_cnt       <= 3'd0;
      rx_shift      <= 7'd0;
      tx_shift      <= 7'd0;
      spi_miso      <= 1'b0;
      byte_valid    <= 1'b0;
      rx_byte       <= 8'd0;
      opcode        <= OP_NONE;
      payload_index <= 2'd0;
    end else begin
      byte_valid <= 1'b0;
      if (byte_valid && (payload_index != 2'd3))
        payload_index <= payload_index + 2'd1; // step after the byte is reported

      if (sck_rise && (state != ST_IDLE)) begin
        rx_shift <= rx_next[6:0];
        bit_cnt  <= bit_cnt + 3'd1; // wraps to 0 at byte end
      end

      if (!ss_active) begin
        state    <= ST_IDLE; // partial byte dropped
        bit_cnt  <= 3'd0;
        spi_miso <= 1'b0;
      end else begin
        case (state)
          ST_IDLE: begin
            state         <= ST_OPCODE;
            bit_cnt       <= 3'd0;
            payload_index <= 2'd0;
            spi_miso      <= CORE_ID[7]; // msb valid before first rise
            tx_shift      <= CORE_ID[6:0];
          end
          ST_OPCODE: begin
            if (sck_fall) begin
              spi_miso <= tx_shift[6];
              tx_shift <= {tx_shift[5:0], 1'b0};
            end
            if (byte_done) begin
              opcode <= map_opcode(rx_next);
              state  <= ST_PAYLOAD;
            end
          end
          ST_PAYLOAD: begin
            if (sck_fall)
              spi_miso <= 1'b0; // nothing to return on payload
            if (byte_done) begin
              byte_valid <= 1'b1;
              rx_byte    <= rx_next;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- src/user_io_pkg.sv
//////////////////////////////////////////////////
// user_io types: frame opcodes, decoder
// states, kbd / mouse event types
//////////////////////////////////////////////////

`default_nettype none

package user_io_pkg;

  // first byte of every frame
  typedef enum logic [7:0] {
    OP_NONE    = 8'h00, // unknown opcodes land here
    OP_BUTTONS = 8'h01, // buttons [1:0], switches [3:2]
    OP_JOY0    = 8'h02, // joystick 0 [5:0]
    OP_JOY1    = 8'h03, // joystick 1 [5:0]
    OP_MOUSE   = 8'h04, // x, y, buttons
    OP_KBD     = 8'h05  // keycode stream
  } uio_opcode_e;

  // frame position in the decoder
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0, // ss_n high
    ST_OPCODE  = 2'd1, // first byte, core id on miso
    ST_PAYLOAD = 2'd2  // everything after
  } dec_state_e;

  // tag carried with each queued event
  typedef enum logic [1:0] {
    KM_MOUSE_X = 2'd0, // signed x step
    KM_MOUSE_Y = 2'd1, // signed y step
    KM_KEY     = 2'd2  // keycode
  } km_type_e;

endpackage

`default_nettype wire

//--- src/user_io_defs.svh
//////////////////////////////////////////////////
// user_io sizing macros: core id on MISO,
// event queue depth, credits granted at reset
//////////////////////////////////////////////////

`ifndef USER_IO_DEFS_SVH
`define USER_IO_DEFS_SVH

`default_nettype none

// id shifted out during the opcode byte
`define USER_IO_CORE_ID 8'ha1 // minimig core id

// kbd / mouse event fifo, power of two
`define HID_QUEUE_DEPTH 8 // entries

// credits the core hands out after reset
`define HID_INIT_CREDITS 2 // also the ceiling

`default_nettype wire

`endif
